//--- design/centroid_fsm.sv
`timescale 1ns/10ps

module centroid_fsm (
  input  logic                          clk_pixel,
  input  logic                          sys_rst,
  input  logic                          sums_ready,
  input  logic [tracker_pkg::SUM_W-1:0] sum_x,
  input  logic [tracker_pkg::SUM_W-1:0] sum_y,
  input  logic [tracker_pkg::CNT_W-1:0] count,
  input  logic [tracker_pkg::H_W-1:0]   quotient,
  input  logic                          done,
  output logic                          start,
  output logic [tracker_pkg::SUM_W-1:0] dividend,
  output logic [tracker_pkg::CNT_W-1:0] divisor,
  output logic [tracker_pkg::H_W-1:0]   com_x,
  output logic [tracker_pkg::V_W-1:0]   com_y,
  output logic                          com_valid
);

  logic [1:0]                  state;
  logic [tracker_pkg::H_W-1:0] quo_x; // x result parked while y divides

  // divider operands follow the state, count holds until the next frame
  assign dividend  = (state == tracker_pkg::ST_DIV_Y) ? sum_y : sum_x;
  assign divisor   = count;
  assign com_valid = (state == tracker_pkg::ST_PUBLISH);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state <= tracker_pkg::ST_IDLE;
      start <= 1'b0;
      com_x <= tracker_pkg::COM_X_RESET;
      com_y <= tracker_pkg::COM_Y_RESET;
    end else begin
      start <= 1'b0; // single-cycle pulse
      case (state)
        tracker_pkg::ST_IDLE: begin
          if (sums_ready && count != '0) begin // empty frame keeps the old centre
            start <= 1'b1;
            state <= tracker_pkg::ST_DIV_X;
          end
        end
        tracker_pkg::ST_DIV_X: begin
          if (done) begin
            start <= 1'b1; // straight into the y division
            state <= tracker_pkg::ST_DIV_Y;
          end
        end
        tracker_pkg::ST_DIV_Y: begin
          if (done) begin
            com_x <= quo_x; // both axes change on the same edge
            com_y <= quotient[tracker_pkg::V_W-1:0];
            state <= tracker_pkg::ST_PUBLISH;
          end
        end
        default: state <= tracker_pkg::ST_IDLE; // publish lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (state == tracker_pkg::ST_DIV_X && done) quo_x <= quotient;
  end

  a_valid_pulse: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    com_valid |=> !com_valid);

endmodule

//--- design/channel_mask.sv
`timescale 1ns/10ps

module channel_mask (
  input  logic                        clk_pixel,
  input  logic                        sys_rst,
  input  logic [15:0]                 pixel_in,    // 5-6-5 camera pixel
  input  logic [1:0]                  channel_sel,
  input  logic [7:0]                  lower_bound,
  input  logic [7:0]                  upper_bound,
  input  logic [tracker_pkg::H_W-1:0] hcount,
  input  logic [tracker_pkg::V_W-1:0] vcount,
  input  logic                        active,
  input  logic                        frame_end,
  output logic                        mask,
  output logic [tracker_pkg::H_W-1:0] mask_x,
  output logic [tracker_pkg::V_W-1:0] mask_y,
  output logic                        frame_done
);

  logic [7:0] red, green, blue;
  logic [7:0] sel_val;
  logic       in_range;

  // widen to 8 bits, zeros on the right
  assign red   = {pixel_in[15:11], 3'b000};
  assign green = {pixel_in[10:5], 2'b00};
  assign blue  = {pixel_in[4:0], 3'b000};

  always_comb begin
    case (channel_sel)
      tracker_pkg::CH_GREEN: sel_val = green;
      tracker_pkg::CH_RED:   sel_val = red;
      tracker_pkg::CH_BLUE:  sel_val = blue;
      default:               sel_val = 8'd0; // invalid code
    endcase
  end

  // inclusive window, blanking never passes
  assign in_range = active && (sel_val >= lower_bound) && (sel_val <= upper_bound);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      mask       <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      mask       <= in_range;
      frame_done <= frame_end; // delayed with the mask so the last pixel lands first
    end
  end

  always_ff @(posedge clk_pixel) begin
    mask_x <= hcount; // coordinate travels with its mask bit
    mask_y <= vcount;
  end

endmodule

//--- design/crosshair_overlay.sv
`timescale 1ns/10ps

module crosshair_overlay (
  input  logic                        clk_pixel,
  input  logic                        sys_rst,
  input  logic [15:0]                 pixel_in,   // 5-6-5 camera pixel
  input  logic [tracker_pkg::H_W-1:0] hcount,
  input  logic [tracker_pkg::V_W-1:0] vcount,
  input  logic                        active,
  input  logic [tracker_pkg::H_W-1:0] com_x,
  input  logic [tracker_pkg::V_W-1:0] com_y,
  output logic [23:0]                 video_out,  // red in the top byte
  output logic                        video_valid
);

  logic [23:0] cam_rgb;
  logic        on_cross;

  // same zero-fill widening as the mask path
  assign cam_rgb = {pixel_in[15:11], 3'b000,
                    pixel_in[10:5], 2'b00,
                    pixel_in[4:0], 3'b000};

  // full-height column and full-width row through the centre
  assign on_cross = (hcount == com_x) || (vcount == com_y);

  always_ff @(posedge clk_pixel) begin
    if (on_cross) begin
      video_out <= {3{tracker_pkg::CROSS_LEVEL}}; // grey on all channels
    end else begin
      video_out <= cam_rgb;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      video_valid <= 1'b0;
    end else begin
      video_valid <= active; // lines up with video_out
    end
  end

endmodule

//--- design/mass_accumulator.sv
`timescale 1ns/10ps

module mass_accumulator (
  input  logic                          clk_pixel,
  input  logic                          sys_rst,
  input  logic                          mask,
  input  logic [tracker_pkg::H_W-1:0]   mask_x,
  input  logic [tracker_pkg::V_W-1:0]   mask_y,
  input  logic                          frame_done,
  output logic [tracker_pkg::SUM_W-1:0] sum_x,
  output logic [tracker_pkg::SUM_W-1:0] sum_y,
  output logic [tracker_pkg::CNT_W-1:0] count,
  output logic                          sums_ready
);

  logic [tracker_pkg::SUM_W-1:0] acc_x, acc_y;
  logic [tracker_pkg::CNT_W-1:0] acc_n;
  logic [tracker_pkg::SUM_W-1:0] tot_x, tot_y; // totals including this cycle
  logic [tracker_pkg::CNT_W-1:0] tot_n;

  always_comb begin
    tot_x = acc_x;
    tot_y = acc_y;
    tot_n = acc_n;
    if (mask) begin
      tot_x = acc_x + {{(tracker_pkg::SUM_W - tracker_pkg::H_W){1'b0}}, mask_x};
      tot_y = acc_y + {{(tracker_pkg::SUM_W - tracker_pkg::V_W){1'b0}}, mask_y};
      tot_n = acc_n + 1'b1;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      acc_x      <= '0;
      acc_y      <= '0;
      acc_n      <= '0;
      sums_ready <= 1'b0;
    end else begin
      sums_ready <= frame_done; // totals visible from the next cycle
      if (frame_done) begin
        acc_x <= '0; // new frame starts from scratch
        acc_y <= '0;
        acc_n <= '0;
      end else begin
        acc_x <= tot_x;
        acc_y <= tot_y;
        acc_n <= tot_n;
      end
    end
  end

  // handed-over totals hold until the next frame end
  always_ff @(posedge clk_pixel) begin
    if (frame_done) begin
      sum_x <= tot_x;
      sum_y <= tot_y;
      count <= tot_n;
    end
  end

  a_no_count_wrap: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    mask |-> acc_n != {tracker_pkg::CNT_W{1'b1}});

endmodule

//--- design/raster_counter.sv
`timescale 1ns/10ps

module raster_counter (
  input  logic                       clk_pixel,
  input  logic                       sys_rst,
  output logic [tracker_pkg::H_W-1:0] hcount,
  output logic [tracker_pkg::V_W-1:0] vcount,
  output logic                       active,
  output logic                       frame_end
);

  logic [tracker_pkg::H_W-1:0] h_next;
  logic [tracker_pkg::V_W-1:0] v_next;
  logic                        line_wrap;

  assign line_wrap = (hcount == tracker_pkg::H_TOTAL - 1); // last column of the line

  always_comb begin
    h_next = line_wrap ? '0 : hcount + 1'b1;
    v_next = vcount;
    if (line_wrap) begin
      v_next = (vcount == tracker_pkg::V_TOTAL - 1) ? '0 : vcount + 1'b1; // frame wrap
    end
  end

  // visible window sits top left, blanking to the right and below
  assign active = (hcount < tracker_pkg::H_ACTIVE) && (vcount < tracker_pkg::V_ACTIVE);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      hcount    <= '0;
      vcount    <= '0;
      frame_end <= 1'b0;
    end else begin
      hcount    <= h_next;
      vcount    <= v_next;
      frame_end <= (h_next == '0) && (v_next == tracker_pkg::V_ACTIVE); // first blank line
    end
  end

  a_h_range: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    hcount < tracker_pkg::H_TOTAL);

  // registered pulse must land exactly on the decoded position
  a_frame_end_pos: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    frame_end |-> (hcount == '0) && (vcount == tracker_pkg::V_ACTIVE));

endmodule

//--- design/serial_divider.sv
`timescale 1ns/10ps

module serial_divider (
  input  logic                          clk_pixel,
  input  logic                          sys_rst,
  input  logic                          start,
  input  logic [tracker_pkg::SUM_W-1:0] dividend,
  input  logic [tracker_pkg::CNT_W-1:0] divisor,
  output logic [tracker_pkg::H_W-1:0]   quotient,
  output logic                          done
);

  logic [tracker_pkg::CNT_W-1:0]     rem, rem_n;  // partial remainder, always below divisor
  logic [tracker_pkg::SUM_W-1:0]     dq, dq_n;    // dividend shifting out, quotient in
  logic [tracker_pkg::CNT_W-1:0]     div_q;       // divisor held for the run
  logic [tracker_pkg::CNT_W:0]       shifted, diff;
  logic [tracker_pkg::CNT_W-1:0]     d_use, r_use;
  logic [tracker_pkg::SUM_W-1:0]     n_use;
  logic [$clog2(tracker_pkg::SUM_W)-1:0] bit_cnt;
  logic                              busy;
  logic                              fits;

  // first step runs straight from the inputs on the start cycle
  always_comb begin
    d_use   = start ? divisor : div_q;
    r_use   = start ? '0 : rem;
    n_use   = start ? dividend : dq;
    shifted = {r_use, n_use[tracker_pkg::SUM_W-1]};
    diff    = shifted - {1'b0, d_use};
    fits    = shifted >= {1'b0, d_use};
    rem_n   = fits ? diff[tracker_pkg::CNT_W-1:0] : shifted[tracker_pkg::CNT_W-1:0]; // restore
    dq_n    = {n_use[tracker_pkg::SUM_W-2:0], fits};
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end else if (busy) begin
        if (bit_cnt == tracker_pkg::SUM_W - 2) begin // SUM_W steps taken
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (start || busy) begin
      rem <= rem_n;
      dq  <= dq_n;
    end
    if (start) div_q <= divisor;
  end

  assign quotient = dq[tracker_pkg::H_W-1:0]; // centre always fits a coordinate

  // sequencer must wait for done before the next division
  a_start_idle: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    start |-> !busy);

endmodule

//--- design/tracker_pkg.sv
package tracker_pkg;

  // camera raster, blanking included in the totals
  localparam int H_ACTIVE = 320;
  localparam int H_TOTAL  = 400;
  localparam int V_ACTIVE = 240;
  localparam int V_TOTAL  = 260;

  localparam int H_W   = 9;  // column coordinate width
  localparam int V_W   = 9;  // line coordinate width
  localparam int SUM_W = 25; // full-frame coordinate sum
  localparam int CNT_W = 17; // up to 320*240 mask pixels

  // channel select codes, 3 is invalid and reads as zero
  localparam logic [1:0] CH_GREEN = 2'd0;
  localparam logic [1:0] CH_RED   = 2'd1;
  localparam logic [1:0] CH_BLUE  = 2'd2;

  localparam logic [7:0] CROSS_LEVEL = 8'hF2; // crosshair grey, same on r g b

  // centre of mass before the first valid frame
  localparam logic [H_W-1:0] COM_X_RESET = H_W'(160);
  localparam logic [V_W-1:0] COM_Y_RESET = V_W'(120);

  // centroid sequencer states
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_DIV_X   = 2'd1;
  localparam logic [1:0] ST_DIV_Y   = 2'd2;
  localparam logic [1:0] ST_PUBLISH = 2'd3;

endpackage

//--- design/tracker_top.sv
`timescale 1ns/10ps

module tracker_top (
  input  logic                        clk_pixel,
  input  logic                        sys_rst,
  input  logic [15:0]                 pixel_in,
  input  logic [1:0]                  channel_sel,
  input  logic [7:0]                  lower_bound,
  input  logic [7:0]                  upper_bound,
  output logic [tracker_pkg::H_W-1:0] hcount,
  output logic [tracker_pkg::V_W-1:0] vcount,
  output logic                        active,
  output logic [23:0]                 video_out,
  output logic                        video_valid,
  output logic [tracker_pkg::H_W-1:0] com_x,
  output logic [tracker_pkg::V_W-1:0] com_y,
  output logic                        com_valid
);

  logic                          frame_end;
  logic                          mask, frame_done;
  logic [tracker_pkg::H_W-1:0]   mask_x;
  logic [tracker_pkg::V_W-1:0]   mask_y;
  logic [tracker_pkg::SUM_W-1:0] sum_x, sum_y;
  logic [tracker_pkg::CNT_W-1:0] count;
  logic                          sums_ready;
  logic                          div_start, div_done;
  logic [tracker_pkg::SUM_W-1:0] dividend;
  logic [tracker_pkg::CNT_W-1:0] divisor;
  logic [tracker_pkg::H_W-1:0]   quotient;

  raster_counter u_raster (
    .clk_pixel, .sys_rst, .hcount, .vcount, .active, .frame_end
  );

  // pixel stream -> mask bit, one cycle
  channel_mask u_mask (
    .clk_pixel, .sys_rst, .pixel_in, .channel_sel, .lower_bound, .upper_bound,
    .hcount, .vcount, .active, .frame_end,
    .mask, .mask_x, .mask_y, .frame_done
  );

  mass_accumulator u_accum (
    .clk_pixel, .sys_rst, .mask, .mask_x, .mask_y, .frame_done,
    .sum_x, .sum_y, .count, .sums_ready
  );

  // one divider shared by both axes
  serial_divider u_div (
    .clk_pixel, .sys_rst, .start(div_start), .dividend, .divisor,
    .quotient, .done(div_done)
  );

  centroid_fsm u_fsm (
    .clk_pixel, .sys_rst, .sums_ready, .sum_x, .sum_y, .count,
    .quotient, .done(div_done), .start(div_start), .dividend, .divisor,
    .com_x, .com_y, .com_valid
  );

  crosshair_overlay u_overlay (
    .clk_pixel, .sys_rst, .pixel_in, .hcount, .vcount, .active,
    .com_x, .com_y, .video_out, .video_valid
  );

endmodule

//--- sim/tracker_tb.sv
`timescale 1ns/10ps

module tracker_tb;

  localparam int RUN_CYCLES = 6 * tracker_pkg::H_TOTAL * tracker_pkg::V_TOTAL; // six frames

  logic                        clk_pixel = 1'b0;
  logic                        sys_rst;
  logic [15:0]                 pixel_in;
  logic [1:0]                  channel_sel;
  logic [7:0]                  lower_bound, upper_bound;
  logic [tracker_pkg::H_W-1:0] hcount, com_x;
  logic [tracker_pkg::V_W-1:0] vcount, com_y;
  logic                        active, video_valid, com_valid;
  logic [23:0]                 video_out;

  // reference model
  int          h_ref, v_ref, frame_ref, cfg_frame, cycles;
  longint      acc_sx, acc_sy, acc_n;       // running totals of the expected mask
  int          exp_cx, exp_cy;              // centre the next pulse must carry
  int          shown_cx, shown_cy;          // centre the overlay should be drawing
  int          pulses, exp_pulses, total_pulses;
  logic        act_ref, pass_ref, act_d;
  logic [23:0] exp_vid;
  int          mismatch_errs = 0;
  int          other_errs = 0;

  tracker_top dut (
    .clk_pixel, .sys_rst, .pixel_in, .channel_sel, .lower_bound, .upper_bound,
    .hcount, .vcount, .active, .video_out, .video_valid, .com_x, .com_y, .com_valid
  );

  always #2 clk_pixel = ~clk_pixel; // 4 ns pixel clock

  // one solid rectangle per frame with none in frames 0 and 5
  function automatic logic in_rect(input int f, input int h, input int v);
    case (f)
      1:       return h >= 40 && h <= 99 && v >= 30 && v <= 69;
      2:       return h >= 200 && h <= 263 && v >= 150 && v <= 210;
      3:       return h >= 5 && h <= 310 && v >= 100 && v <= 102;
      4:       return h >= 120 && h <= 180 && v >= 60 && v <= 90;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [15:0] rect_colour(input int f);
    case (f)
      1:       return 16'hF800; // red reads F8
      2:       return 16'h001F; // blue reads F8
      3:       return 16'h07E0; // green reads FC
      default: return 16'hFFFF;
    endcase
  endfunction

  // msb of every channel clear so each widened value stays below 80
  function automatic logic [15:0] background(input logic [8:0] h, input logic [8:0] v);
    return {1'b0, h[3:0], 1'b0, v[4:0], 1'b0, h[7:4]};
  endfunction

  function automatic logic [23:0] widen(input logic [15:0] pix);
    return {pix[15:11], 3'b000, pix[10:5], 2'b00, pix[4:0], 3'b000};
  endfunction

  task automatic apply_config(input int f);
    case (f)
      1: begin
        channel_sel = tracker_pkg::CH_RED;
        lower_bound = 8'hC0;
        upper_bound = 8'hF8;
      end
      2: begin
        channel_sel = tracker_pkg::CH_BLUE;
        lower_bound = 8'hF8;
        upper_bound = 8'hF8;
      end
      3: begin
        channel_sel = tracker_pkg::CH_GREEN;
        lower_bound = 8'h80;
        upper_bound = 8'hFC;
      end
      4: begin
        channel_sel = tracker_pkg::CH_GREEN;
        lower_bound = 8'hFF; // empty window
        upper_bound = 8'h00;
      end
      default: begin
        channel_sel = tracker_pkg::CH_RED; // no rectangle and the background fails
        lower_bound = 8'hC0;
        upper_bound = 8'hF8;
      end
    endcase
  endtask

  assign act_ref  = (h_ref < tracker_pkg::H_ACTIVE) && (v_ref < tracker_pkg::V_ACTIVE);
  assign pass_ref = act_ref && frame_ref >= 1 && frame_ref <= 3 && in_rect(frame_ref, h_ref, v_ref);

  // stimulus on the falling edge with levels changing only in the last blank cycle
  always @(negedge clk_pixel) begin
    if (!sys_rst && hcount == tracker_pkg::H_TOTAL - 1 && vcount == tracker_pkg::V_TOTAL - 1) begin
      cfg_frame = cfg_frame + 1;
      apply_config(cfg_frame);
    end
    pixel_in <= in_rect(cfg_frame, hcount, vcount) ? rect_colour(cfg_frame)
                                                   : background(hcount, vcount);
  end

  always @(posedge clk_pixel) begin
    if (sys_rst) begin
      h_ref        <= 0;
      v_ref        <= 0;
      frame_ref    <= 0;
      acc_sx       <= 0;
      acc_sy       <= 0;
      acc_n        <= 0;
      exp_cx       <= tracker_pkg::COM_X_RESET;
      exp_cy       <= tracker_pkg::COM_Y_RESET;
      shown_cx     <= tracker_pkg::COM_X_RESET;
      shown_cy     <= tracker_pkg::COM_Y_RESET;
      pulses       <= 0;
      exp_pulses   <= 0;
      total_pulses <= 0;
      act_d        <= 1'b0;
      cycles       <= 0;
    end else begin
      cycles  <= cycles + 1;
      act_d   <= act_ref;
      exp_vid <= (h_ref == shown_cx || v_ref == shown_cy) ? {3{tracker_pkg::CROSS_LEVEL}}
                                                          : widen(pixel_in);
      if (com_valid) begin
        pulses       <= pulses + 1;
        total_pulses <= total_pulses + 1;
      end
      if (h_ref == tracker_pkg::H_TOTAL - 1) begin
        h_ref <= 0;
        if (v_ref == tracker_pkg::V_TOTAL - 1) begin
          v_ref     <= 0;
          frame_ref <= frame_ref + 1;
          shown_cx  <= exp_cx; // centre published in the blanking is drawn from here on
          shown_cy  <= exp_cy;
        end else begin
          v_ref <= v_ref + 1;
        end
      end else begin
        h_ref <= h_ref + 1;
      end
      if (pass_ref) begin
        acc_sx <= acc_sx + h_ref;
        acc_sy <= acc_sy + v_ref;
        acc_n  <= acc_n + 1;
      end
      if (h_ref == 0 && v_ref == tracker_pkg::V_ACTIVE) begin // first blank line
        acc_sx     <= 0;
        acc_sy     <= 0;
        acc_n      <= 0;
        exp_pulses <= (acc_n != 0) ? 1 : 0;
        if (acc_n != 0) begin
          exp_cx <= int'(acc_sx / acc_n); // floor since totals are never negative
          exp_cy <= int'(acc_sy / acc_n);
        end
      end
      if (h_ref == 0 && v_ref == 0) pulses <= 0; // fresh count per frame
    end
  end

  a_reset_state: assert property (@(posedge clk_pixel) $fell(sys_rst) |->
      com_x == tracker_pkg::COM_X_RESET && com_y == tracker_pkg::COM_Y_RESET &&
      !com_valid && !video_valid)
    else begin
      mismatch_errs = mismatch_errs + 1;
      $display("Mismatch at %0t: after reset centre %0d,%0d com_valid %b video_valid %b",
               $time, $sampled(com_x), $sampled(com_y), $sampled(com_valid),
               $sampled(video_valid));
    end

  a_raster: assert property (@(posedge clk_pixel) disable iff (sys_rst)
      hcount == h_ref && vcount == v_ref && active == act_ref)
    else begin
      mismatch_errs = mismatch_errs + 1;
      $display("Mismatch at %0t: raster %0d,%0d active %b, expected %0d,%0d active %b", $time,
               $sampled(hcount), $sampled(vcount), $sampled(active),
               $sampled(h_ref), $sampled(v_ref), $sampled(act_ref));
    end

  a_centre_value: assert property (@(posedge clk_pixel) disable iff (sys_rst)
      com_valid |-> com_x == exp_cx && com_y == exp_cy)
    else begin
      mismatch_errs = mismatch_errs + 1;
      $display("Mismatch at %0t: centre %0d,%0d expected %0d,%0d", $time,
               $sampled(com_x), $sampled(com_y), $sampled(exp_cx), $sampled(exp_cy));
    end

  // centre may only move together with its pulse
  a_centre_hold: assert property (@(posedge clk_pixel) disable iff (sys_rst)
      !com_valid |-> $stable(com_x) && $stable(com_y))
    else begin
      other_errs = other_errs + 1;
      $display("Centre changed at %0t without a com_valid pulse", $time);
    end

  a_pulses_per_frame: assert property (@(posedge clk_pixel) disable iff (sys_rst)
      (h_ref == 0 && v_ref == 0 && frame_ref > 0) |-> pulses == exp_pulses)
    else begin
      mismatch_errs = mismatch_errs + 1;
      $display("Mismatch at %0t: %0d com_valid pulses in frame %0d, expected %0d", $time,
               $sampled(pulses), $sampled(frame_ref) - 1, $sampled(exp_pulses));
    end

  a_video_valid: assert property (@(posedge clk_pixel) disable iff (sys_rst)
      video_valid == act_d)
    else begin
      mismatch_errs = mismatch_errs + 1;
      $display("Mismatch at %0t: video_valid %b expected %b", $time,
               $sampled(video_valid), $sampled(act_d));
    end

  a_video_out: assert property (@(posedge clk_pixel) disable iff (sys_rst)
      video_valid |-> video_out == exp_vid)
    else begin
      mismatch_errs = mismatch_errs + 1;
      $display("Mismatch at %0t: video_out %h expected %h", $time,
               $sampled(video_out), $sampled(exp_vid));
    end

  initial begin
    sys_rst   = 1'b1;
    pixel_in  = 16'h0000;
    cfg_frame = 0;
    apply_config(0);
    repeat (2) @(negedge clk_pixel);
    sys_rst <= 1'b0;
    wait (cycles == RUN_CYCLES); // run length bounds the simulation
    @(negedge clk_pixel);
    if (total_pulses != 3) begin // frames 1 to 3 each publish once
      other_errs = other_errs + 1;
      $display("Expected three centre updates over the run but saw %0d", total_pulses);
    end
    $display("Error count: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- src.f
design/tracker_pkg.sv
design/raster_counter.sv
design/channel_mask.sv
design/mass_accumulator.sv
design/serial_divider.sv
design/centroid_fsm.sv
design/crosshair_overlay.sv
design/tracker_top.sv
sim/tracker_tb.sv
